/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_load_store_unit
FILELIST = flist.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+.
lsu_pkg.sv
pipe_stage.sv
lsu_req_gen.sv
lsu_resp.sv
load_store_unit.sv
tb_sram_model.sv
tb_load_store_unit.sv

/* load_store_unit.sv */
`timescale 1ns/1ns

module load_store_unit (
    input logic aclk,
    input logic aresetn,
    input logic op_valid,
    input lsu_pkg::lsu_op_t op,
    input logic result_allow,
    input lsu_pkg::sram_resp_t sram_resp,
    output logic op_allow,
    output logic result_valid,
    output lsu_pkg::lsu_result_t result,
    output lsu_pkg::sram_req_t sram_req
);

    import lsu_pkg::*;

    // request stage
    logic req_stage_valid;
    logic req_valid_out;
    logic req_ready_go;
    lsu_op_t req_op;
    mem_pend_t req_pend;

    // response stage
    logic resp_allow_in;
    logic resp_stage_valid;
    logic resp_ready_go;
    mem_pend_t resp_pend;

    pipe_stage #(
        .T(lsu_op_t)
    ) u_req_stage (
        .aclk(aclk),
        .aresetn(aresetn),
        .valid_in(op_valid),
        .data_in(op),
        .ready_go(req_ready_go),
        .allow_out(resp_allow_in),
        .allow_in(op_allow),
        .valid_out(req_valid_out),
        .valid(req_stage_valid),
        .data_out(req_op)
    );

    lsu_req_gen u_req_gen (
        .stage_valid(req_stage_valid),
        .op(req_op),
        .next_allow(resp_allow_in),
        .addr_ok(sram_resp.addr_ok),
        .sram_req(sram_req),
        .ready_go(req_ready_go),
        .pend(req_pend)
    );

    pipe_stage #(
        .T(mem_pend_t)
    ) u_resp_stage (
        .aclk(aclk),
        .aresetn(aresetn),
        .valid_in(req_valid_out),
        .data_in(req_pend),
        .ready_go(resp_ready_go),
        .allow_out(result_allow),
        .allow_in(resp_allow_in),
        .valid_out(result_valid),
        .valid(resp_stage_valid),
        .data_out(resp_pend)
    );

    lsu_resp u_resp (
        .aclk(aclk),
        .aresetn(aresetn),
        .stage_valid(resp_stage_valid),
        .pend(resp_pend),
        .data_ok(sram_resp.data_ok),
        .rdata(sram_resp.rdata),
        .result_allow(result_allow),
        .ready_go(resp_ready_go),
        .result(result)
    );

endmodule

/* lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// datapath widths
`define LSU_XLEN 32
`define LSU_STRB_W 4
`define LSU_REG_W 5

// sram size field, same codes as the bus
`define LSU_SIZE_W 2
`define LSU_SIZE_BYTE 2'd0
`define LSU_SIZE_HALF 2'd1
`define LSU_SIZE_WORD 2'd2

// operation kind codes
`define LSU_OP_W 2

// reset values of the control flags
`define LSU_VALID_RST 1'b0

`endif

/* lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;
    typedef logic [`LSU_STRB_W-1:0] strb_t;
    typedef logic [`LSU_REG_W-1:0] reg_no_t;

    typedef enum logic [`LSU_SIZE_W-1:0] {
        MEM_SIZE_BYTE = `LSU_SIZE_BYTE,
        MEM_SIZE_HALF = `LSU_SIZE_HALF,
        MEM_SIZE_WORD = `LSU_SIZE_WORD
    } mem_size_e;

    typedef enum logic [`LSU_OP_W-1:0] {
        MEM_OP_NONE  = 2'd0,
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2
    } mem_op_e;

    // alu_result doubles as the address for loads and stores
    typedef struct packed {
        mem_op_e   kind;
        mem_size_e size;
        logic      is_unsigned;
        logic      wen;
        reg_no_t   rd;
        word_t     alu_result;
        word_t     store_data;
    } lsu_op_t;

    // what the response stage needs while the data is outstanding
    typedef struct packed {
        mem_op_e kind;
        logic    is_unsigned;
        logic    wen;
        reg_no_t rd;
        word_t   alu_result;
        strb_t   strb;
    } mem_pend_t;

    typedef struct packed {
        logic    wen;
        reg_no_t rd;
        word_t   data;
    } lsu_result_t;

    typedef struct packed {
        logic      req;
        logic      wr;
        mem_size_e size;
        word_t     addr;
        strb_t     wstrb;
        word_t     wdata;
    } sram_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } sram_resp_t;

endpackage

/* lsu_req_gen.sv */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_req_gen (
    input logic stage_valid,
    input lsu_pkg::lsu_op_t op,
    input logic next_allow,
    input logic addr_ok,
    output lsu_pkg::sram_req_t sram_req,
    output logic ready_go,
    output lsu_pkg::mem_pend_t pend
);

    import lsu_pkg::*;

    logic is_mem;
    word_t addr;
    strb_t strb;
    word_t wdata;

    assign is_mem = (op.kind != MEM_OP_NONE);
    assign addr = op.alu_result;

    // lane select from the low address bits
    always_comb begin
        unique case (op.size)
            MEM_SIZE_BYTE: begin
                strb = strb_t'(1) << addr[1:0];
            end
            MEM_SIZE_HALF: begin
                // odd halfword falls back to the aligned one below
                strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SIZE_WORD: begin
                strb = '1;
            end
            default: begin
                strb = '1;
            end
        endcase
    end

    // replicate store data across all lanes
    always_comb begin
        unique case (op.size)
            MEM_SIZE_BYTE: begin
                wdata = {`LSU_STRB_W{op.store_data[7:0]}};
            end
            MEM_SIZE_HALF: begin
                wdata = {(`LSU_STRB_W / 2){op.store_data[15:0]}};
            end
            default: begin
                wdata = op.store_data;
            end
        endcase
    end

    // only issue once the response stage can take the op
    assign sram_req.req = stage_valid & is_mem & next_allow;
    assign sram_req.wr = (op.kind == MEM_OP_STORE);
    assign sram_req.size = op.size;
    assign sram_req.addr = addr;
    assign sram_req.wstrb = strb;
    assign sram_req.wdata = wdata;

    assign ready_go = ~is_mem | (sram_req.req & addr_ok);

    assign pend.kind = op.kind;
    assign pend.is_unsigned = op.is_unsigned;
    assign pend.wen = op.wen;
    assign pend.rd = op.rd;
    assign pend.alu_result = op.alu_result;
    assign pend.strb = strb;

endmodule

/* lsu_resp.sv */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_resp (
    input logic aclk,
    input logic aresetn,
    input logic stage_valid,
    input lsu_pkg::mem_pend_t pend,
    input logic data_ok,
    input lsu_pkg::word_t rdata,
    input logic result_allow,
    output logic ready_go,
    output lsu_pkg::lsu_result_t result
);

    import lsu_pkg::*;

    logic is_mem;
    logic hold_valid;
    word_t hold_data;
    word_t load_word;
    word_t ext_data;

    function automatic word_t ext_byte(input logic [7:0] b, input logic zext);
        logic sign;
        sign = b[7] & ~zext;
        return {{(`LSU_XLEN - 8){sign}}, b};
    endfunction

    function automatic word_t ext_half(input logic [15:0] h, input logic zext);
        logic sign;
        sign = h[15] & ~zext;
        return {{(`LSU_XLEN - 16){sign}}, h};
    endfunction

    assign is_mem = (pend.kind != MEM_OP_NONE);

    // a full hold buffer means the data already came back
    assign ready_go = ~is_mem | data_ok | hold_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold_valid <= `LSU_VALID_RST;
        end else if (stage_valid && data_ok && !result_allow) begin
            hold_valid <= 1'b1;
        end else if (hold_valid && result_allow) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (stage_valid && data_ok && !result_allow) begin
            hold_data <= rdata;
        end
    end

    assign load_word = hold_valid ? hold_data : rdata;

    // shift the strobed lanes down and extend
    always_comb begin
        unique case (pend.strb)
            4'b0001: ext_data = ext_byte(load_word[7:0], pend.is_unsigned);
            4'b0010: ext_data = ext_byte(load_word[15:8], pend.is_unsigned);
            4'b0100: ext_data = ext_byte(load_word[23:16], pend.is_unsigned);
            4'b1000: ext_data = ext_byte(load_word[31:24], pend.is_unsigned);
            4'b0011: ext_data = ext_half(load_word[15:0], pend.is_unsigned);
            4'b1100: ext_data = ext_half(load_word[31:16], pend.is_unsigned);
            default: ext_data = load_word;
        endcase
    end

    // stores still report a result, with no register write
    assign result.wen = pend.wen & (pend.kind != MEM_OP_STORE);
    assign result.rd = pend.rd;
    assign result.data = (pend.kind == MEM_OP_LOAD) ? ext_data : pend.alu_result;

endmodule

/* pipe_stage.sv */
`timescale 1ns/1ns
`include "lsu_config.svh"

module pipe_stage #(
    parameter type T = logic
) (
    input logic aclk,
    input logic aresetn,
    input logic valid_in,
    input T data_in,
    input logic ready_go,
    input logic allow_out,
    output logic allow_in,
    output logic valid_out,
    // raw occupancy, before ready_go
    output logic valid,
    output T data_out
);

    logic valid_q;

    // empty, or the current entry leaves this cycle
    assign allow_in = ~valid_q | (ready_go & allow_out);
    assign valid_out = valid_q & ready_go;
    assign valid = valid_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_q <= `LSU_VALID_RST;
        end else if (allow_in) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge aclk) begin
        if (allow_in && valid_in) begin
            data_out <= data_in;
        end
    end

endmodule

/* tb_load_store_unit.sv */
`timescale 1ns/1ns
`include "lsu_config.svh"

module tb_load_store_unit;

    import lsu_pkg::*;

    localparam int N_OPS = 143;

    logic aclk;
    logic aresetn;
    logic op_valid;
    lsu_op_t op;
    logic result_allow = 1'b1;
    sram_resp_t sram_resp;
    logic op_allow;
    logic result_valid;
    lsu_result_t result;
    sram_req_t sram_req;
    logic [1:0] addr_wait = 2'd0;
    logic [1:0] data_wait = 2'd0;

    logic [15:0] lfsr_state = 16'd48967;
    logic [7:0] mirror [0:255];
    lsu_result_t exp_res_q[$];
    sram_req_t exp_req_q[$];
    string cur_test = "reset";
    logic rand_delay = 1'b0;
    logic stall_on = 1'b0;
    logic [1:0] stall_left = 2'd0;

    load_store_unit u_load_store_unit (
        .aclk(aclk),
        .aresetn(aresetn),
        .op_valid(op_valid),
        .op(op),
        .result_allow(result_allow),
        .sram_resp(sram_resp),
        .op_allow(op_allow),
        .result_valid(result_valid),
        .result(result),
        .sram_req(sram_req)
    );

    tb_sram_model u_sram (
        .aclk(aclk),
        .aresetn(aresetn),
        .sram_req(sram_req),
        .addr_wait(addr_wait),
        .data_wait(data_wait),
        .sram_resp(sram_resp)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #4 aclk = ~aclk;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input lsu_result_t exp, input lsu_result_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_now("result differs");
        end
    endtask

    task automatic check_strb(input string name, input strb_t exp, input strb_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_now("strobe differs");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_now("data word differs");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            fail_now("control bit differs");
        end
    endtask

    task automatic check_size(input string name, input mem_size_e exp, input mem_size_e act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_now("access size differs");
        end
    endtask

    // lane l is strobed when it falls inside the access
    function automatic strb_t lane_mask(input mem_size_e size, input word_t addr);
        strb_t m;
        for (int l = 0; l < 4; l++) begin
            m[l] = (size == MEM_SIZE_WORD) || (size == MEM_SIZE_HALF && l[1] == addr[1])
                || (size == MEM_SIZE_BYTE && l[1:0] == addr[1:0]);
        end
        return m;
    endfunction

    function automatic word_t lane_data(input mem_size_e size, input word_t d);
        word_t w;
        for (int l = 0; l < 4; l++) begin
            if (size == MEM_SIZE_BYTE) w[8*l +: 8] = d[7:0];
            else if (size == MEM_SIZE_HALF) w[8*l +: 8] = d[8*(l % 2) +: 8];
            else w[8*l +: 8] = d[8*l +: 8];
        end
        return w;
    endfunction

    // gather strobed lanes from the mirror, then extend
    function automatic word_t mirror_load(input lsu_op_t o);
        strb_t m;
        word_t v;
        int k;
        logic sign;
        m = lane_mask(o.size, o.alu_result);
        v = '0;
        k = 0;
        for (int l = 0; l < 4; l++) begin
            if (m[l]) begin
                v[8*k +: 8] = mirror[{o.alu_result[7:2], 2'(l)}];
                k++;
            end
        end
        sign = v[8*k-1] & ~o.is_unsigned;
        for (int b = 8 * k; b < 32; b++) begin
            v[b] = sign;
        end
        return v;
    endfunction

    task automatic expect_op(input lsu_op_t o);
        lsu_result_t r;
        sram_req_t q;
        strb_t m;
        word_t w;
        m = lane_mask(o.size, o.alu_result);
        w = lane_data(o.size, o.store_data);
        q = '{req: 1'b1, wr: o.kind == MEM_OP_STORE, size: o.size, addr: o.alu_result,
              wstrb: m, wdata: w};
        r = '{wen: o.wen, rd: o.rd, data: o.alu_result};
        if (o.kind == MEM_OP_LOAD) begin
            r.data = mirror_load(o);
            exp_req_q.push_back(q);
        end else if (o.kind == MEM_OP_STORE) begin
            r.wen = 1'b0;
            for (int l = 0; l < 4; l++) begin
                if (m[l]) mirror[{o.alu_result[7:2], 2'(l)}] = w[8*l +: 8];
            end
            exp_req_q.push_back(q);
        end
        exp_res_q.push_back(r);
    endtask

    task automatic send_op(input lsu_op_t o);
        @(negedge aclk);
        op_valid = 1'b1;
        op = o;
        do begin
            @(posedge aclk);
        end while (!op_allow);
        expect_op(o);
    endtask

    task automatic end_stream();
        @(negedge aclk);
        op_valid = 1'b0;
        while (exp_res_q.size() != 0) begin
            @(posedge aclk);
        end
    endtask

    function automatic lsu_op_t make_op(input mem_op_e kind, input mem_size_e size,
                                        input logic uns, input word_t addr, input word_t sd);
        return '{kind: kind, size: size, is_unsigned: uns, wen: 1'b1,
                 rd: reg_no_t'(addr[4:0] ^ 5'd9), alu_result: addr, store_data: sd};
    endfunction

    task automatic random_op(input logic load_heavy, output lsu_op_t o);
        logic [31:0] r;
        logic [31:0] d;
        mem_op_e kind;
        mem_size_e size;
        take_bits(2, r);
        if (load_heavy) kind = (r[1:0] == 2'd0) ? MEM_OP_STORE : MEM_OP_LOAD;
        else kind = (r[1:0] == 2'd3) ? MEM_OP_LOAD : mem_op_e'(r[1:0]);
        take_bits(2, r);
        size = (r[1:0] == 2'd3) ? MEM_SIZE_WORD : mem_size_e'(r[1:0]);
        take_bits(32, d);
        take_bits(16, r);
        o = make_op(kind, size, r[8], {24'd0, r[7:0]}, d);
        o.wen = r[9];
        o.rd = r[14:10];
    endtask

    // SRAM delays and consumer stalls
    always @(negedge aclk) begin
        logic [31:0] r;
        if (rand_delay) begin
            take_bits(2, r);
            addr_wait = r[1:0];
            take_bits(2, r);
            data_wait = r[1:0];
        end else begin
            addr_wait = 2'd0;
            data_wait = 2'd0;
        end
        if (!stall_on) begin
            result_allow = 1'b1;
        end else if (stall_left != 2'd0) begin
            stall_left = stall_left - 2'd1;
        end else begin
            take_bits(3, r);
            result_allow = r[0];
            stall_left = r[2:1];
        end
    end

    always @(posedge aclk) begin
        if (aresetn && result_valid && result_allow) begin
            if (exp_res_q.size() == 0) fail_now("a result came out with nothing outstanding");
            else check_result(cur_test, exp_res_q.pop_front(), result);
        end
    end

    always @(posedge aclk) begin
        sram_req_t q;
        if (aresetn && sram_req.req && sram_resp.addr_ok) begin
            if (exp_req_q.size() == 0) begin
                fail_now("an SRAM request was issued with no memory op outstanding");
            end else begin
                q = exp_req_q.pop_front();
                check_flag(cur_test, q.wr, sram_req.wr);
                check_size(cur_test, q.size, sram_req.size);
                check_word(cur_test, q.addr, sram_req.addr);
                check_strb(cur_test, q.wstrb, sram_req.wstrb);
                if (q.wr) check_word(cur_test, q.wdata, sram_req.wdata);
            end
        end
    end

    task automatic test_none_ops();
        logic [31:0] r;
        lsu_op_t o;
        cur_test = "none_ops";
        for (int i = 0; i < 8; i++) begin
            take_bits(32, r);
            o = make_op(MEM_OP_NONE, MEM_SIZE_WORD, 1'b0, r, 32'd0);
            o.wen = r[5];
            send_op(o);
            if (i == 0) begin
                @(negedge aclk);
                op_valid = 1'b0;
                @(posedge aclk);
                check_flag("none_ops latency", 1'b0, result_valid);
                @(posedge aclk);
                check_flag("none_ops latency", 1'b1, result_valid);
            end
        end
        end_stream();
    endtask

    task automatic test_store_sizes();
        logic [31:0] r;
        cur_test = "store_sizes";
        for (int i = 0; i < 9; i++) begin
            take_bits(32, r);
            if (i < 4) send_op(make_op(MEM_OP_STORE, MEM_SIZE_BYTE, 1'b0, 32'h20 + i, r));
            else if (i < 8) send_op(make_op(MEM_OP_STORE, MEM_SIZE_HALF, 1'b0, 32'h20 + i - 4, r));
            else send_op(make_op(MEM_OP_STORE, MEM_SIZE_WORD, 1'b0, 32'h20, r));
            send_op(make_op(MEM_OP_LOAD, MEM_SIZE_WORD, 1'b0, 32'h20, 32'd0));
        end
        end_stream();
    endtask

    task automatic test_load_extend();
        cur_test = "load_extend";
        send_op(make_op(MEM_OP_STORE, MEM_SIZE_WORD, 1'b0, 32'h40, 32'h8a7f_f501));
        for (int i = 0; i < 8; i++) begin
            send_op(make_op(MEM_OP_LOAD, MEM_SIZE_BYTE, i[2], 32'h40 + 32'(i[1:0]), 32'd0));
            send_op(make_op(MEM_OP_LOAD, MEM_SIZE_HALF, i[2], 32'h40 + 32'(i[1:0]), 32'd0));
        end
        end_stream();
    endtask

    task automatic test_back_pressure();
        lsu_op_t o;
        cur_test = "back_pressure";
        rand_delay = 1'b1;
        stall_on = 1'b1;
        for (int i = 0; i < 40; i++) begin
            random_op(1'b1, o);
            send_op(o);
        end
        end_stream();
        stall_on = 1'b0;
    endtask

    task automatic test_mixed_stream();
        lsu_op_t o;
        cur_test = "mixed_stream";
        rand_delay = 1'b1;
        for (int i = 0; i < 60; i++) begin
            random_op(1'b0, o);
            send_op(o);
        end
        end_stream();
    endtask

    initial begin
        repeat (8 + N_OPS * 20) @(posedge aclk);
        fail_now("watchdog expired before all tests finished");
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mirror[i] = 8'(i * 29 + 113);
        end
        aresetn = 1'b0;
        op_valid = 1'b0;
        op = '0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        test_none_ops();
        test_store_sizes();
        test_load_extend();
        test_back_pressure();
        test_mixed_stream();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tb_sram_model.sv */
`timescale 1ns/1ns
`include "lsu_config.svh"

module tb_sram_model (
    input logic aclk,
    input logic aresetn,
    input lsu_pkg::sram_req_t sram_req,
    input logic [1:0] addr_wait,
    input logic [1:0] data_wait,
    output lsu_pkg::sram_resp_t sram_resp
);

    import lsu_pkg::*;

    logic [7:0] mem [0:255];
    logic [2:0] addr_cnt;
    logic addr_ok;
    logic accept;
    logic pend_busy;
    logic [1:0] pend_cnt;
    word_t pend_data;
    logic data_ok_q;
    word_t rdata_q;
    logic [7:0] base;

    // fill depends on every address bit
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 29 + 113);
        end
    end

    assign base = {sram_req.addr[7:2], 2'b00};
    assign addr_ok = sram_req.req && (addr_cnt >= {1'b0, addr_wait});
    assign accept = aresetn && addr_ok;
    assign sram_resp = {addr_ok, data_ok_q, rdata_q};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            addr_cnt <= '0;
        end else if (!sram_req.req || addr_ok) begin
            addr_cnt <= '0;
        end else if (addr_cnt != 3'd7) begin
            addr_cnt <= addr_cnt + 3'd1;
        end
    end

    // one response per request, in order
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pend_busy <= 1'b0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            if (pend_busy) begin
                if (pend_cnt == 2'd0) begin
                    data_ok_q <= 1'b1;
                    rdata_q <= pend_data;
                    pend_busy <= 1'b0;
                end else begin
                    pend_cnt <= pend_cnt - 2'd1;
                end
            end
            if (accept) begin
                pend_busy <= 1'b1;
                pend_cnt <= data_wait;
                pend_data <= {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && sram_req.wr) begin
            for (int l = 0; l < 4; l++) begin
                if (sram_req.wstrb[l]) begin
                    mem[base + 8'(l)] <= sram_req.wdata[8*l +: 8];
                end
            end
        end
    end

endmodule
